// File: Bender.yml
package:
  name: issue_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/cdb_pkg.sv
      - hw/rs_types_pkg.sv
      - hw/psel_generic.sv
      - hw/rs_station.sv
      - hw/fu_alu.sv
      - hw/fu_mult.sv
      - hw/cdb_arbiter.sv
      - hw/issue_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/issue_core_assert.sv
      - tb/issue_core_tb.sv

// File: hw/cdb_arbiter.sv
// Fixed-priority CDB arbiter steering up to two unit results onto the bus
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module cdb_arbiter
	import cdb_pkg::*;
(
	input  logic  [`NUM_FU-1:0] done_valid,
	input  tag_t  [`NUM_FU-1:0] done_tag,
	input  data_t [`NUM_FU-1:0] done_value,
	output logic  [`NUM_FU-1:0] done_grant,
	output logic  [`SS_SIZE-1:0] cdb_valid,
	output tag_t  [`SS_SIZE-1:0] cdb_tag,
	output data_t [`SS_SIZE-1:0] cdb_value
);

	// Multiplier holds the oldest work so it drains first
	localparam fu_idx_t PRIO [`NUM_FU] = '{fu_mult0, fu_alu0, fu_alu1};
	localparam int PRIO_W = $clog2(`NUM_FU);

	logic [`NUM_FU-1:0] req_ord;
	logic [`SS_SIZE-1:0][PRIO_W-1:0] gnt_pos;
	logic [`SS_SIZE-1:0] gnt_valid;

	// Requests in priority order
	always_comb begin
		for (int p = 0; p < `NUM_FU; p++) begin
			req_ord[p] = done_valid[PRIO[p]];
		end
	end

	psel_generic #(.WIDTH(`NUM_FU), .NUM_REQS(`SS_SIZE)) psel_cdb (
		.req(req_ord),
		.gnt_idx(gnt_pos),
		.gnt_valid(gnt_valid)
	);

	// Map priority positions back to units
	always_comb begin
		done_grant = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		cdb_value = '0;
		for (int s = 0; s < `SS_SIZE; s++) begin
			if (gnt_valid[s]) begin
				done_grant[PRIO[gnt_pos[s]]] = 1'b1;
				cdb_valid[s] = 1'b1;
				cdb_tag[s] = done_tag[PRIO[gnt_pos[s]]];
				cdb_value[s] = done_value[PRIO[gnt_pos[s]]];
			end
		end
	end

endmodule

// File: hw/cdb_pkg.sv
// CDB tag and data types, functional unit index enum
`include "issue_core_defines.svh"

package cdb_pkg;

	// Physical register tag carried on the CDB
	typedef logic [`TAG_W-1:0] tag_t;

	// Result payload
	typedef logic [`DATA_W-1:0] data_t;

	// Unit slots, ALUs first so they index from zero
	typedef enum logic [1:0] {
		fu_alu0  = 2'd0,
		fu_alu1  = 2'd1,
		fu_mult0 = 2'd2
	} fu_idx_t;

endpackage

// File: hw/fu_alu.sv
// Single-cycle ALU with a result register held until a CDB grant
`timescale 1ns/1ps

module fu_alu
	import rs_types_pkg::*, cdb_pkg::*;
(
	input  logic    clock,
	input  logic    rst_n,
	input  logic    flush,
	input  logic    issue_valid,
	input  alu_op_t issue_op,
	input  tag_t    issue_dest,
	input  data_t   issue_a,
	input  data_t   issue_b,
	input  logic    done_grant,
	output logic    issue_stall,
	output logic    done_valid,
	output tag_t    done_tag,
	output data_t   done_value
);

	data_t result;

	always_comb begin
		case (issue_op)
			op_add: result = issue_a + issue_b;
			op_sub: result = issue_a - issue_b;
			op_and: result = issue_a & issue_b;
			default: result = issue_a ^ issue_b;
		endcase
	end

	// A granted result frees the register for this edge
	assign issue_stall = done_valid && !done_grant;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			done_valid <= 1'b0;
		end else if (issue_valid) begin
			done_valid <= 1'b1;
		end else if (done_grant) begin
			done_valid <= 1'b0;
		end
	end

	// Payload only moves on a new issue
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			done_tag <= issue_dest;
			done_value <= result;
		end
	end

endmodule

// File: hw/fu_mult.sv
// Pipelined multiplier keeping the low product bits, whole pipe stalls on an ungranted output
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module fu_mult
	import cdb_pkg::*;
(
	input  logic  clock,
	input  logic  rst_n,
	input  logic  flush,
	input  logic  issue_valid,
	input  tag_t  issue_dest,
	input  data_t issue_a,
	input  data_t issue_b,
	input  logic  done_grant,
	output logic  issue_stall,
	output logic  done_valid,
	output tag_t  done_tag,
	output data_t done_value
);

	localparam int LAST = `MULT_STAGES - 1;

	logic [LAST:0] stg_valid;
	tag_t [LAST:0] stg_tag;
	data_t [LAST:0] stg_value;
	data_t product;
	logic advance;

	// Result width truncates to the low half
	assign product = issue_a * issue_b;

	////////////////////////////////////////
	// Flow control
	////////////////////////////////////////

	// Move only when the output stage is empty or leaving
	assign advance = !stg_valid[LAST] || done_grant;
	assign issue_stall = !advance;

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			stg_valid <= '0;
		end else if (advance) begin
			stg_valid <= {stg_valid[LAST-1:0], issue_valid};
		end
	end

	////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////

	// Later stages give the multiply array room to be retimed
	always_ff @(posedge clock) begin
		if (advance) begin
			stg_tag[0] <= issue_dest;
			stg_value[0] <= product;
			for (int s = 1; s <= LAST; s++) begin
				stg_tag[s] <= stg_tag[s-1];
				stg_value[s] <= stg_value[s-1];
			end
		end
	end

	assign done_valid = stg_valid[LAST];
	assign done_tag = stg_tag[LAST];
	assign done_value = stg_value[LAST];

endmodule

// File: hw/issue_core.sv
// Issue core top level joining station, ALUs, multiplier and CDB arbiter
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module issue_core
	import rs_types_pkg::*, cdb_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	// Branch mispredict
	input  logic      flush,
	input  logic      [`SS_SIZE-1:0] dispatch_valid,
	input  fu_class_t [`SS_SIZE-1:0] disp_class,
	input  alu_op_t   [`SS_SIZE-1:0] disp_op,
	input  tag_t      [`SS_SIZE-1:0] disp_dest,
	input  tag_t      [`SS_SIZE-1:0] disp_src1_tag,
	input  logic      [`SS_SIZE-1:0] disp_src1_ready,
	input  data_t     [`SS_SIZE-1:0] disp_src1_value,
	input  tag_t      [`SS_SIZE-1:0] disp_src2_tag,
	input  logic      [`SS_SIZE-1:0] disp_src2_ready,
	input  data_t     [`SS_SIZE-1:0] disp_src2_value,
	output logic      [`SS_SIZE-1:0] cdb_valid,
	output tag_t      [`SS_SIZE-1:0] cdb_tag,
	output data_t     [`SS_SIZE-1:0] cdb_value,
	output logic      [$clog2(`RS_SIZE):0] free_rows,
	output logic      rs_full
);

	////////////////////////////////////////
	// Station to unit wiring
	////////////////////////////////////////

	logic    [`NUM_FU-1:0] issue_valid;
	alu_op_t [`NUM_ALU-1:0] issue_op;
	tag_t    [`NUM_FU-1:0] issue_dest;
	data_t   [`NUM_FU-1:0] issue_a;
	data_t   [`NUM_FU-1:0] issue_b;
	logic    [`NUM_FU-1:0] issue_stall;

	// Unit results toward the arbiter
	logic    [`NUM_FU-1:0] done_valid;
	tag_t    [`NUM_FU-1:0] done_tag;
	data_t   [`NUM_FU-1:0] done_value;
	logic    [`NUM_FU-1:0] done_grant;

	// CDB outputs also drive wakeup
	rs_station station (
		.clock,
		.rst_n,
		.flush,
		.dispatch_valid,
		.disp_class,
		.disp_op,
		.disp_dest,
		.disp_src1_tag,
		.disp_src1_ready,
		.disp_src1_value,
		.disp_src2_tag,
		.disp_src2_ready,
		.disp_src2_value,
		.cdb_valid,
		.cdb_tag,
		.cdb_value,
		.issue_stall,
		.issue_valid,
		.issue_op,
		.issue_dest,
		.issue_a,
		.issue_b,
		.free_rows,
		.rs_full
	);

	for (genvar g = 0; g < `NUM_ALU; g++) begin : gen_alu
		fu_alu alu (
			.clock,
			.rst_n,
			.flush,
			.issue_valid(issue_valid[g]),
			.issue_op(issue_op[g]),
			.issue_dest(issue_dest[g]),
			.issue_a(issue_a[g]),
			.issue_b(issue_b[g]),
			.done_grant(done_grant[g]),
			.issue_stall(issue_stall[g]),
			.done_valid(done_valid[g]),
			.done_tag(done_tag[g]),
			.done_value(done_value[g])
		);
	end

	fu_mult mult (
		.clock,
		.rst_n,
		.flush,
		.issue_valid(issue_valid[fu_mult0]),
		.issue_dest(issue_dest[fu_mult0]),
		.issue_a(issue_a[fu_mult0]),
		.issue_b(issue_b[fu_mult0]),
		.done_grant(done_grant[fu_mult0]),
		.issue_stall(issue_stall[fu_mult0]),
		.done_valid(done_valid[fu_mult0]),
		.done_tag(done_tag[fu_mult0]),
		.done_value(done_value[fu_mult0])
	);

	cdb_arbiter arbiter (
		.done_valid,
		.done_tag,
		.done_value,
		.done_grant,
		.cdb_valid,
		.cdb_tag,
		.cdb_value
	);

endmodule

// File: hw/issue_core_defines.svh
// Sizing macros for dispatch width, station depth, tag and data widths, unit counts
`ifndef ISSUE_CORE_DEFINES_SVH
`define ISSUE_CORE_DEFINES_SVH

////////////////////////////////////////
// Superscalar width
////////////////////////////////////////

// Dispatch slots per cycle, also the number of CDB slots
`define SS_SIZE 2

// Reservation station rows
`define RS_SIZE 8

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Physical register tag
`define TAG_W 6
// Operand and result width
`define DATA_W 16

////////////////////////////////////////
// Functional units
////////////////////////////////////////

`define NUM_ALU 2
// Two ALUs plus one multiplier
`define NUM_FU 3
`define MULT_STAGES 3

`endif

// File: hw/psel_generic.sv
// Multi-grant priority selector, lowest request index wins first
`timescale 1ns/1ps

module psel_generic #(
	parameter int WIDTH = 8,
	parameter int NUM_REQS = 2
) (
	input  logic [WIDTH-1:0] req,
	output logic [NUM_REQS-1:0][$clog2(WIDTH)-1:0] gnt_idx,
	output logic [NUM_REQS-1:0] gnt_valid
);

	localparam int IDX_W = $clog2(WIDTH);

	// Grant k goes to the k-th set request bit
	always_comb begin
		int unsigned n;
		n = 0;
		gnt_idx = '0;
		gnt_valid = '0;
		for (int i = 0; i < WIDTH; i++) begin
			// Stop handing out grants once all are taken
			if (req[i] && n < NUM_REQS) begin
				gnt_idx[n] = IDX_W'(i);
				gnt_valid[n] = 1'b1;
				n++;
			end
		end
	end

endmodule

// File: hw/rs_station.sv
// Reservation station table with dispatch allocation, CDB wakeup, issue select and flush
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module rs_station
	import rs_types_pkg::*, cdb_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  logic flush,
	// Dispatch slots
	input  logic      [`SS_SIZE-1:0] dispatch_valid,
	input  fu_class_t [`SS_SIZE-1:0] disp_class,
	input  alu_op_t   [`SS_SIZE-1:0] disp_op,
	input  tag_t      [`SS_SIZE-1:0] disp_dest,
	input  tag_t      [`SS_SIZE-1:0] disp_src1_tag,
	input  logic      [`SS_SIZE-1:0] disp_src1_ready,
	input  data_t     [`SS_SIZE-1:0] disp_src1_value,
	input  tag_t      [`SS_SIZE-1:0] disp_src2_tag,
	input  logic      [`SS_SIZE-1:0] disp_src2_ready,
	input  data_t     [`SS_SIZE-1:0] disp_src2_value,
	// Broadcasts for wakeup
	input  logic      [`SS_SIZE-1:0] cdb_valid,
	input  tag_t      [`SS_SIZE-1:0] cdb_tag,
	input  data_t     [`SS_SIZE-1:0] cdb_value,
	// Issue to units, indexed by fu_idx_t
	input  logic      [`NUM_FU-1:0] issue_stall,
	output logic      [`NUM_FU-1:0] issue_valid,
	// Multiplier has no opcode
	output alu_op_t   [`NUM_ALU-1:0] issue_op,
	output tag_t      [`NUM_FU-1:0] issue_dest,
	output data_t     [`NUM_FU-1:0] issue_a,
	output data_t     [`NUM_FU-1:0] issue_b,
	output logic      [$clog2(`RS_SIZE):0] free_rows,
	output logic      rs_full
);

	localparam int IDX_W = $clog2(`RS_SIZE);

	rs_row_t [`RS_SIZE-1:0] rs_table;
	rs_row_t [`RS_SIZE-1:0] rs_next;

	logic [`RS_SIZE-1:0] free_req;
	logic [`RS_SIZE-1:0] alu_req;
	logic [`RS_SIZE-1:0] mult_req;
	logic [`SS_SIZE-1:0][IDX_W-1:0] free_idx;
	logic [`SS_SIZE-1:0] free_gnt;
	logic [`NUM_ALU-1:0][IDX_W-1:0] alu_idx;
	logic [`NUM_ALU-1:0] alu_gnt;
	logic [0:0][IDX_W-1:0] mult_idx;
	logic [0:0] mult_gnt;
	// Row chosen for each unit
	logic [`NUM_FU-1:0][IDX_W-1:0] sel_row;
	logic [`NUM_FU-1:0] sel_valid;

	// Capture a broadcast value for a waiting source
	function automatic src_t snoop(src_t src);
		src_t res;
		res = src;
		for (int s = 0; s < `SS_SIZE; s++) begin
			if (!src.ready && cdb_valid[s] && src.tag == cdb_tag[s]) begin
				res.ready = 1'b1;
				res.value = cdb_value[s];
			end
		end
		return res;
	endfunction

	////////////////////////////////////////
	// Requests from the registered table
	////////////////////////////////////////

	always_comb begin
		logic rdy;
		free_rows = '0;
		for (int r = 0; r < `RS_SIZE; r++) begin
			// Ready bits are registered so a woken row waits one cycle
			rdy = rs_table[r].busy && rs_table[r].src1.ready && rs_table[r].src2.ready;
			free_req[r] = !rs_table[r].busy;
			alu_req[r] = rdy && rs_table[r].fu_class == class_alu;
			mult_req[r] = rdy && rs_table[r].fu_class == class_mult;
			free_rows = free_rows + {{IDX_W{1'b0}}, free_req[r]};
		end
	end

	assign rs_full = (free_rows == '0);

	// Lowest free rows for the dispatch slots
	psel_generic #(.WIDTH(`RS_SIZE), .NUM_REQS(`SS_SIZE)) psel_free (
		.req(free_req),
		.gnt_idx(free_idx),
		.gnt_valid(free_gnt)
	);

	// Oldest position first among ready ALU rows
	psel_generic #(.WIDTH(`RS_SIZE), .NUM_REQS(`NUM_ALU)) psel_alu (
		.req(alu_req),
		.gnt_idx(alu_idx),
		.gnt_valid(alu_gnt)
	);

	psel_generic #(.WIDTH(`RS_SIZE), .NUM_REQS(1)) psel_mult (
		.req(mult_req),
		.gnt_idx(mult_idx),
		.gnt_valid(mult_gnt)
	);

	////////////////////////////////////////
	// Issue steering
	////////////////////////////////////////

	always_comb begin
		int unsigned k;
		k = 0;
		sel_row = '0;
		sel_valid = '0;
		// Grants fill the ALUs that can accept, in unit order
		for (int u = 0; u < `NUM_ALU; u++) begin
			if (!issue_stall[u]) begin
				sel_row[u] = alu_idx[k];
				sel_valid[u] = alu_gnt[k];
				k++;
			end
		end
		sel_row[fu_mult0] = mult_idx[0];
		sel_valid[fu_mult0] = mult_gnt[0] && !issue_stall[fu_mult0];
	end

	always_comb begin
		for (int u = 0; u < `NUM_FU; u++) begin
			issue_valid[u] = sel_valid[u];
			issue_dest[u] = rs_table[sel_row[u]].dest;
			issue_a[u] = rs_table[sel_row[u]].src1.value;
			issue_b[u] = rs_table[sel_row[u]].src2.value;
		end
		for (int u = 0; u < `NUM_ALU; u++) begin
			issue_op[u] = rs_table[sel_row[u]].op;
		end
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		rs_row_t row;
		rs_next = rs_table;
		// Wakeup
		for (int r = 0; r < `RS_SIZE; r++) begin
			if (rs_table[r].busy) begin
				rs_next[r].src1 = snoop(rs_table[r].src1);
				rs_next[r].src2 = snoop(rs_table[r].src2);
			end
		end
		// Issued rows leave
		for (int u = 0; u < `NUM_FU; u++) begin
			if (sel_valid[u]) begin
				rs_next[sel_row[u]].busy = 1'b0;
			end
		end
		// Dispatch writes, with bypass from this cycle's CDB
		for (int d = 0; d < `SS_SIZE; d++) begin
			row.busy = 1'b1;
			row.fu_class = disp_class[d];
			row.op = disp_op[d];
			row.dest = disp_dest[d];
			row.src1 = snoop(src_t'{tag: disp_src1_tag[d], ready: disp_src1_ready[d],
				value: disp_src1_value[d]});
			row.src2 = snoop(src_t'{tag: disp_src2_tag[d], ready: disp_src2_ready[d],
				value: disp_src2_value[d]});
			if (dispatch_valid[d] && free_gnt[d]) begin
				rs_next[free_idx[d]] = row;
			end
		end
	end

	// Flush drops every row at once
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			rs_table <= '0;
		end else begin
			rs_table <= rs_next;
		end
	end

endmodule

// File: hw/rs_types_pkg.sv
// Unit class and ALU opcode enums, reservation station row struct
package rs_types_pkg;

	import cdb_pkg::*;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// Which kind of unit a row needs
	typedef enum logic {
		class_alu  = 1'b0,
		class_mult = 1'b1
	} fu_class_t;

	// ALU operations
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_and = 2'd2,
		op_xor = 2'd3
	} alu_op_t;

	////////////////////////////////////////
	// Station row
	////////////////////////////////////////

	// One source operand, tag is only meaningful while not ready
	typedef struct packed {
		tag_t  tag;
		logic  ready;
		data_t value;
	} src_t;

	typedef struct packed {
		logic      busy;
		fu_class_t fu_class;
		alu_op_t   op;
		tag_t      dest;
		src_t      src1;
		src_t      src2;
	} rs_row_t;

endpackage

// File: issue_core.f
+incdir+hw
hw/cdb_pkg.sv
hw/rs_types_pkg.sv
hw/psel_generic.sv
hw/rs_station.sv
hw/fu_alu.sv
hw/fu_mult.sv
hw/cdb_arbiter.sv
hw/issue_core.sv
tb/issue_core_assert.sv
tb/issue_core_tb.sv

// File: tb/issue_core_assert.sv
// Concurrent protocol checks on the issue core ports, bound to the top level
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module issue_core_assert
	import cdb_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic flush,
	input logic [`SS_SIZE-1:0] cdb_valid,
	input tag_t [`SS_SIZE-1:0] cdb_tag,
	input logic [$clog2(`RS_SIZE):0] free_rows,
	input logic rs_full
);

	// Read by the testbench monitor
	int unsigned error_count = 0;

	////////////////////////////////////////
	// Reset and flush
	////////////////////////////////////////

	// Empty station and quiet bus out of reset
	reset_state: assert property (@(posedge clock)
		$rose(rst_n) |-> cdb_valid == '0 && free_rows == `RS_SIZE)
	else begin
		$error("Station not empty or CDB active after reset");
		error_count++;
	end

	// Rows and unit results dropped one edge later
	flush_clears: assert property (@(posedge clock) disable iff (!rst_n)
		flush |=> free_rows == `RS_SIZE && cdb_valid == '0)
	else begin
		$error("Flush left rows or results behind");
		error_count++;
	end

	////////////////////////////////////////
	// Occupancy and bus
	////////////////////////////////////////

	full_flag: assert property (@(posedge clock) disable iff (!rst_n)
		rs_full == (free_rows == 0) && free_rows <= `RS_SIZE)
	else begin
		$error("rs_full disagrees with free_rows");
		error_count++;
	end

	distinct_slots: assert property (@(posedge clock) disable iff (!rst_n)
		&cdb_valid |-> cdb_tag[0] != cdb_tag[1])
	else begin
		$error("Both CDB slots carry the same tag");
		error_count++;
	end

endmodule

bind issue_core issue_core_assert issue_core_assert_inst (.*);

// File: tb/issue_core_tb.sv
// Issue core testbench with clock, reset, dispatch stimulus, reference model and result checks
`timescale 1ns/1ps
`include "issue_core_defines.svh"

module issue_core_tb
	import rs_types_pkg::*, cdb_pkg::*;
();

	localparam int LAST_TAG = 63;
	// Two ALU result registers plus three multiplier stages
	localparam int UNIT_SLOTS = 5;
	localparam int TIMEOUT = 300;

	typedef enum int {st_free, st_pending, st_done, st_flushed} tag_state_t;

	logic clock = 1'b0;
	logic rst_n;
	logic flush;
	logic      [`SS_SIZE-1:0] dispatch_valid;
	fu_class_t [`SS_SIZE-1:0] disp_class;
	alu_op_t   [`SS_SIZE-1:0] disp_op;
	tag_t      [`SS_SIZE-1:0] disp_dest;
	tag_t      [`SS_SIZE-1:0] disp_src1_tag;
	logic      [`SS_SIZE-1:0] disp_src1_ready;
	data_t     [`SS_SIZE-1:0] disp_src1_value;
	tag_t      [`SS_SIZE-1:0] disp_src2_tag;
	logic      [`SS_SIZE-1:0] disp_src2_ready;
	data_t     [`SS_SIZE-1:0] disp_src2_value;
	logic      [`SS_SIZE-1:0] cdb_valid;
	tag_t      [`SS_SIZE-1:0] cdb_tag;
	data_t     [`SS_SIZE-1:0] cdb_value;
	logic      [$clog2(`RS_SIZE):0] free_rows;
	logic      rs_full;

	// Reference model, one entry per tag
	tag_state_t tag_state [LAST_TAG+1];
	data_t exp_val [LAST_TAG+1];
	int bcast_cycle [LAST_TAG+1];
	int next_tag;
	// Dispatched but not yet seen on the CDB
	int outstanding;
	int cycle_no;
	bit check_reset;
	bit check_flush;
	bit saw_full;

	always #5 clock = ~clock;

	issue_core issue_core_inst (.*);

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////

	task automatic abort_run(string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		abort_run($sformatf("CHECK FAILED at %0t: %s expected %0h, got %0h",
			$time, name, expected, actual));
	endtask

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////

	function automatic data_t expected_result(bit is_mult, alu_op_t op, data_t a, data_t b);
		logic [31:0] prod;
		// Full product, bus keeps the low half
		prod = a * b;
		if (is_mult) begin
			return prod[15:0];
		end
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	function automatic int random_dep(int dep_pct);
		if (next_tag > 1 && $urandom_range(99, 0) < dep_pct) begin
			return $urandom_range(next_tag - 1, 1);
		end
		return 0;
	endfunction

	////////////////////////////////////////
	// Per-cycle monitor
	////////////////////////////////////////

	task automatic check_outputs();
		int occupied;
		tag_t t;
		occupied = `RS_SIZE - free_rows;
		if (issue_core_inst.issue_core_assert_inst.error_count != 0) begin
			abort_run("A bound protocol assertion failed");
		end
		assert (rs_full == (free_rows == 0)) else report_mismatch("rs_full", free_rows == 0, rs_full);
		// Rows left = outstanding minus what sits in the units
		assert (occupied <= outstanding && occupied + UNIT_SLOTS >= outstanding)
		else report_mismatch("free_rows", `RS_SIZE - outstanding, free_rows);
		if (check_reset || check_flush) begin
			assert (free_rows == `RS_SIZE) else report_mismatch("free_rows", `RS_SIZE, free_rows);
			assert (cdb_valid == '0) else report_mismatch("cdb_valid", 0, cdb_valid);
		end
		check_reset = 1'b0;
		check_flush = 1'b0;
		if (free_rows == 0) begin
			saw_full = 1'b1;
		end
		for (int s = 0; s < `SS_SIZE; s++) begin
			if (cdb_valid[s]) begin
				t = cdb_tag[s];
				// Catches repeats, flushed tags and a tag on both slots
				assert (tag_state[t] == st_pending)
				else abort_run($sformatf("Tag %0d broadcast while not pending", t));
				assert (cdb_value[s] == exp_val[t])
				else report_mismatch($sformatf("cdb_value[%0d]", s), exp_val[t], cdb_value[s]);
				tag_state[t] = st_done;
				bcast_cycle[t] = cycle_no;
				outstanding--;
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clock);
		cycle_no++;
		check_outputs();
		dispatch_valid = '0;
		flush = 1'b0;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Wait on a producer still pending or on the bus now, else pass a ready value
	task automatic pick_src(input int dep, output tag_t tag, output logic ready,
		output data_t value, output data_t operand);
		tag = tag_t'($urandom);
		ready = 1'b1;
		value = data_t'($urandom);
		operand = value;
		if (dep > 0 && (tag_state[dep] == st_pending
			|| (tag_state[dep] == st_done && bcast_cycle[dep] == cycle_no))) begin
			tag = tag_t'(dep);
			ready = 1'b0;
			operand = exp_val[dep];
		end else if (dep > 0 && tag_state[dep] == st_done) begin
			value = exp_val[dep];
			operand = value;
		end
	endtask

	task automatic fill_slot(int s, bit is_mult, int dep1, int dep2);
		alu_op_t op;
		tag_t t;
		logic r;
		data_t v;
		data_t a;
		data_t b;
		pick_src(dep1, t, r, v, a);
		disp_src1_tag[s] = t;
		disp_src1_ready[s] = r;
		disp_src1_value[s] = v;
		pick_src(dep2, t, r, v, b);
		disp_src2_tag[s] = t;
		disp_src2_ready[s] = r;
		disp_src2_value[s] = v;
		op = alu_op_t'($urandom_range(3, 0));
		dispatch_valid[s] = 1'b1;
		disp_class[s] = is_mult ? class_mult : class_alu;
		disp_op[s] = op;
		disp_dest[s] = tag_t'(next_tag);
		tag_state[next_tag] = st_pending;
		exp_val[next_tag] = expected_result(is_mult, op, a, b);
		next_tag++;
		outstanding++;
	endtask

	// Up to two per cycle, limited by the rows free in this cycle
	task automatic traffic(int count, int mult_pct, int dep_pct, bit chain);
		int sent;
		int idle;
		int dep1;
		sent = 0;
		idle = 0;
		while (sent < count) begin
			next_cycle();
			idle++;
			for (int s = 0; s < `SS_SIZE; s++) begin
				if (sent < count && s < free_rows) begin
					dep1 = chain ? next_tag - 1 : random_dep(dep_pct);
					fill_slot(s, $urandom_range(99, 0) < mult_pct, dep1, random_dep(dep_pct));
					sent++;
					idle = 0;
				end
			end
			if (idle > TIMEOUT) begin
				abort_run("Timed out waiting for a free station row");
			end
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (outstanding != 0) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timed out waiting for results on the CDB");
			end
		end
		next_cycle();
		assert (free_rows == `RS_SIZE) else report_mismatch("free_rows", `RS_SIZE, free_rows);
	endtask

	initial begin
		void'($urandom(32'h07c0_fe9e));
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = '0;
		disp_class = '0;
		disp_op = '0;
		disp_dest = '0;
		disp_src1_tag = '0;
		disp_src1_ready = '0;
		disp_src1_value = '0;
		disp_src2_tag = '0;
		disp_src2_ready = '0;
		disp_src2_value = '0;
		foreach (tag_state[t]) begin
			tag_state[t] = st_free;
			bcast_cycle[t] = -1;
		end
		next_tag = 1;
		outstanding = 0;
		cycle_no = 0;
		saw_full = 1'b0;
		check_flush = 1'b0;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;
		check_reset = 1'b1;
		// Dependent multiplies back up and fill the station
		traffic(12, 100, 100, 1'b1);
		wait_idle();
		// Independent burst keeping both CDB slots busy
		traffic(20, 50, 0, 1'b0);
		wait_idle();
		// Mixed traffic with wakeup and bypass operands
		traffic(12, 30, 60, 1'b0);
		wait_idle();
		// Mispredict while a chain is still in flight
		traffic(6, 100, 100, 1'b1);
		next_cycle();
		flush = 1'b1;
		foreach (tag_state[t]) begin
			if (tag_state[t] == st_pending) begin
				tag_state[t] = st_flushed;
			end
		end
		outstanding = 0;
		check_flush = 1'b1;
		traffic(10, 40, 60, 1'b0);
		wait_idle();
		if (saw_full && issue_core_inst.issue_core_assert_inst.error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("Station never filled or a bound assertion failed");
		end
	end

endmodule
